//--- files.f
hdl/dsp_backend_pkg.sv
hdl/sample_delay_line.sv
hdl/dsp_cfg_regs.sv
hdl/ffe_datapath.sv
hdl/slicer.sv
hdl/mlsd_checker.sv
hdl/dsp_backend.sv
verification/tb_dsp_backend.sv

//--- hdl/dsp_backend.sv
module dsp_backend #(
	parameter int channel_width = dsp_backend_pkg::channel_width,
	parameter int ffe_length = dsp_backend_pkg::ffe_length
) (
	input logic signed [dsp_backend_pkg::code_precision-1:0] codes_i [channel_width-1:0],

	input logic clk,
	input logic rstb,

	input logic cfg_wr_i,
	input logic [dsp_backend_pkg::cfg_addr_width-1:0] cfg_addr_i,
	input logic [dsp_backend_pkg::cfg_data_width-1:0] cfg_data_i,

	output logic signed [dsp_backend_pkg::output_precision-1:0] estimated_bits_o [channel_width-1:0],
	output logic [channel_width-1:0] checked_bits_o
);

	typedef logic [channel_width-1:0][dsp_backend_pkg::code_precision-1:0] code_word_t;
	typedef logic [channel_width-1:0] bit_word_t;

	code_word_t code_in;
	code_word_t code_hist [3:0];
	bit_word_t sliced;
	bit_word_t bit_hist [1:0];

	logic signed [dsp_backend_pkg::weight_precision-1:0] weights [ffe_length-1:0][channel_width-1:0];
	logic signed [dsp_backend_pkg::thresh_precision-1:0] thresh [channel_width-1:0];
	logic [dsp_backend_pkg::shift_precision-1:0] ffe_shift [channel_width-1:0];
	logic [dsp_backend_pkg::shift_precision-1:0] mlsd_shift [channel_width-1:0];
	logic signed [dsp_backend_pkg::est_precision-1:0] chan_est [channel_width-1:0][1:0];

	for (genvar j = 0; j < channel_width; j++) begin : g_pack
		assign code_in[j] = codes_i[j];
	end

	// stages 0,1 feed the ffe, 2,3 line up with the bit history.
	sample_delay_line #(.payload_t(code_word_t), .depth(4)) code_line (
		.clk(clk),
		.rstb(rstb),
		.in_i(code_in),
		.line_o(code_hist)
	);

	dsp_cfg_regs #(.num_lanes(channel_width), .taps(ffe_length)) cfg_regs_i (
		.clk(clk),
		.rstb(rstb),
		.cfg_wr_i(cfg_wr_i),
		.cfg_addr_i(cfg_addr_i),
		.cfg_data_i(cfg_data_i),
		.weights_o(weights),
		.thresh_o(thresh),
		.ffe_shift_o(ffe_shift),
		.mlsd_shift_o(mlsd_shift),
		.chan_est_o(chan_est)
	);

	ffe_datapath #(.num_lanes(channel_width), .taps(ffe_length)) ffe_i (
		.clk(clk),
		.rstb(rstb),
		.code_cur_i(code_hist[0]),
		.code_prev_i(code_hist[1]),
		.weights_i(weights),
		.shift_i(ffe_shift),
		.est_o(estimated_bits_o)
	);

	slicer #(.num_lanes(channel_width)) slicer_i (
		.clk(clk),
		.rstb(rstb),
		.est_i(estimated_bits_o),
		.thresh_i(thresh),
		.bit_o(sliced)
	);

	sample_delay_line #(.payload_t(bit_word_t), .depth(2)) bit_line (
		.clk(clk),
		.rstb(rstb),
		.in_i(sliced),
		.line_o(bit_hist)
	);

	// the slicer output is one word ahead of bit_hist[0].
	mlsd_checker #(.num_lanes(channel_width)) mlsd_i (
		.clk(clk),
		.rstb(rstb),
		.bits_cur_i(bit_hist[0]),
		.bits_prev_i(bit_hist[1]),
		.bits_next_i(sliced),
		.codes_cur_i(code_hist[3]),
		.codes_next_i(code_hist[2]),
		.chan_est_i(chan_est),
		.shift_i(mlsd_shift),
		.checked_o(checked_bits_o)
	);

endmodule : dsp_backend

//--- hdl/dsp_backend_pkg.sv
package dsp_backend_pkg;

	// lane and tap counts.
	parameter int channel_width = 4;
	parameter int ffe_length = 3;

	// signed adc codes.
	parameter int code_precision = 8;

	// ffe arithmetic.
	parameter int weight_precision = 8;
	parameter int ffe_acc_precision = 19; // room for ffe_length products.
	parameter int output_precision = 10;

	// ffe and mlsd shift fields share one width.
	parameter int shift_precision = 4;

	// slicer.
	parameter int thresh_precision = 10;

	// mlsd cursor and post-cursor estimates.
	parameter int est_precision = 8;
	parameter int err_precision = 12;

	// configuration write port.
	parameter int cfg_addr_width = 6;
	parameter int cfg_data_width = 10;

	// weight for tap k, lane j at cfg_weight_base + k*channel_width + j.
	parameter int cfg_weight_base = 0;

	// one entry per lane.
	parameter int cfg_thresh_base = 12;
	parameter int cfg_ffe_shift_base = 16;
	parameter int cfg_mlsd_shift_base = 20;

	// estimate k of lane j at cfg_chan_est_base + 2*j + k.
	// k = 0 is the cursor, k = 1 the post-cursor.
	parameter int cfg_chan_est_base = 24;

endpackage : dsp_backend_pkg

//--- hdl/dsp_cfg_regs.sv
module dsp_cfg_regs #(
	parameter int num_lanes = dsp_backend_pkg::channel_width,
	parameter int taps = dsp_backend_pkg::ffe_length
) (
	input logic clk,
	input logic rstb,

	input logic cfg_wr_i,
	input logic [dsp_backend_pkg::cfg_addr_width-1:0] cfg_addr_i,
	input logic [dsp_backend_pkg::cfg_data_width-1:0] cfg_data_i,

	output logic signed [dsp_backend_pkg::weight_precision-1:0] weights_o [taps-1:0][num_lanes-1:0],
	output logic signed [dsp_backend_pkg::thresh_precision-1:0] thresh_o [num_lanes-1:0],
	output logic [dsp_backend_pkg::shift_precision-1:0] ffe_shift_o [num_lanes-1:0],
	output logic [dsp_backend_pkg::shift_precision-1:0] mlsd_shift_o [num_lanes-1:0],
	output logic signed [dsp_backend_pkg::est_precision-1:0] chan_est_o [num_lanes-1:0][1:0]
);

	localparam int wp = dsp_backend_pkg::weight_precision;
	localparam int tp = dsp_backend_pkg::thresh_precision;
	localparam int sp = dsp_backend_pkg::shift_precision;
	localparam int hp = dsp_backend_pkg::est_precision;

	int addr;

	assign addr = int'(cfg_addr_i); // zero extended.

	// one field per write, the rest hold.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int j = 0; j < num_lanes; j++) begin
				thresh_o[j] <= '0;
				ffe_shift_o[j] <= '0;
				mlsd_shift_o[j] <= '0;
				chan_est_o[j][0] <= '0;
				chan_est_o[j][1] <= '0;
				for (int k = 0; k < taps; k++) begin
					weights_o[k][j] <= '0;
				end
			end
		end else if (cfg_wr_i) begin
			for (int j = 0; j < num_lanes; j++) begin
				for (int k = 0; k < taps; k++) begin
					if (addr == dsp_backend_pkg::cfg_weight_base + k * num_lanes + j)
						weights_o[k][j] <= cfg_data_i[wp-1:0];
				end
				if (addr == dsp_backend_pkg::cfg_thresh_base + j)
					thresh_o[j] <= cfg_data_i[tp-1:0];
				if (addr == dsp_backend_pkg::cfg_ffe_shift_base + j)
					ffe_shift_o[j] <= cfg_data_i[sp-1:0];
				if (addr == dsp_backend_pkg::cfg_mlsd_shift_base + j)
					mlsd_shift_o[j] <= cfg_data_i[sp-1:0];
				for (int k = 0; k < 2; k++) begin
					if (addr == dsp_backend_pkg::cfg_chan_est_base + 2 * j + k)
						chan_est_o[j][k] <= cfg_data_i[hp-1:0];
				end
			end
		end
	end

endmodule : dsp_cfg_regs

//--- hdl/ffe_datapath.sv
module ffe_datapath #(
	parameter int num_lanes = dsp_backend_pkg::channel_width,
	parameter int taps = dsp_backend_pkg::ffe_length
) (
	input logic clk,
	input logic rstb,

	input logic [num_lanes-1:0][dsp_backend_pkg::code_precision-1:0] code_cur_i,
	input logic [num_lanes-1:0][dsp_backend_pkg::code_precision-1:0] code_prev_i,
	input logic signed [dsp_backend_pkg::weight_precision-1:0] weights_i [taps-1:0][num_lanes-1:0],
	input logic [dsp_backend_pkg::shift_precision-1:0] shift_i [num_lanes-1:0],

	output logic signed [dsp_backend_pkg::output_precision-1:0] est_o [num_lanes-1:0]
);

	localparam int cp = dsp_backend_pkg::code_precision;
	localparam int aw = dsp_backend_pkg::ffe_acc_precision;
	localparam int op = dsp_backend_pkg::output_precision;

	// previous word in 0..num_lanes-1, current word above it.
	logic signed [cp-1:0] hist [2*num_lanes-1:0];
	logic signed [op-1:0] sat [num_lanes-1:0];

	for (genvar j = 0; j < num_lanes; j++) begin : g_hist
		assign hist[j] = $signed(code_prev_i[j]);
		assign hist[num_lanes+j] = $signed(code_cur_i[j]);
	end

	for (genvar j = 0; j < num_lanes; j++) begin : g_lane
		logic signed [aw-1:0] acc;
		logic signed [aw-1:0] acc_sh;
		logic fits;

		always_comb begin
			acc = '0;
			for (int k = 0; k < taps; k++) begin
				acc = acc + weights_i[k][j] * hist[num_lanes+j-k]; // sample n-k.
			end
		end

		assign acc_sh = acc >>> shift_i[j];
		// upper bits all equal to the sign means no overflow.
		assign fits = (&acc_sh[aw-1:op-1]) || !(|acc_sh[aw-1:op-1]);
		assign sat[j] = fits ? acc_sh[op-1:0] : {acc_sh[aw-1], {(op-1){~acc_sh[aw-1]}}};
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int j = 0; j < num_lanes; j++) begin
				est_o[j] <= '0;
			end
		end else begin
			est_o <= sat;
		end
	end

endmodule : ffe_datapath

//--- hdl/mlsd_checker.sv
module mlsd_checker #(
	parameter int num_lanes = dsp_backend_pkg::channel_width
) (
	input logic clk,
	input logic rstb,

	input logic [num_lanes-1:0] bits_cur_i,
	input logic [num_lanes-1:0] bits_prev_i,
	input logic [num_lanes-1:0] bits_next_i,
	input logic [num_lanes-1:0][dsp_backend_pkg::code_precision-1:0] codes_cur_i,
	input logic [num_lanes-1:0][dsp_backend_pkg::code_precision-1:0] codes_next_i,
	input logic signed [dsp_backend_pkg::est_precision-1:0] chan_est_i [num_lanes-1:0][1:0],
	input logic [dsp_backend_pkg::shift_precision-1:0] shift_i [num_lanes-1:0],

	output logic [num_lanes-1:0] checked_o
);

	localparam int cp = dsp_backend_pkg::code_precision;
	localparam int hp = dsp_backend_pkg::est_precision;
	localparam int ew = dsp_backend_pkg::err_precision;
	localparam int pw = hp + 2; // one estimate times a symbol, plus headroom.
	localparam int aw = ew + 2;

	// +h for bit 1, -h for bit 0.
	function automatic logic signed [pw-1:0] sym_term(input logic signed [hp-1:0] h, input logic b);
		logic signed [pw-1:0] hx;
		hx = pw'(h);
		sym_term = b ? hx : -hx;
	endfunction

	function automatic logic [aw-1:0] hyp_err(
		input logic signed [cp-1:0] c_n,
		input logic signed [cp-1:0] c_n1,
		input logic signed [hp-1:0] h0,
		input logic signed [hp-1:0] h1,
		input logic s_prev,
		input logic s_n,
		input logic s_next
	);
		logic signed [pw:0] p_n;
		logic signed [pw:0] p_n1;
		logic signed [pw+1:0] d_n;
		logic signed [pw+1:0] d_n1;
		logic [pw+1:0] a_n;
		logic [pw+1:0] a_n1;
		p_n = sym_term(h0, s_n) + sym_term(h1, s_prev);
		p_n1 = sym_term(h0, s_next) + sym_term(h1, s_n);
		d_n = c_n - p_n;
		d_n1 = c_n1 - p_n1;
		a_n = d_n[pw+1] ? -d_n : d_n;
		a_n1 = d_n1[pw+1] ? -d_n1 : d_n1;
		hyp_err = aw'(a_n) + aw'(a_n1);
	endfunction

	function automatic logic [ew-1:0] sat_err(input logic [aw-1:0] e);
		sat_err = (|e[aw-1:ew]) ? '1 : e[ew-1:0];
	endfunction

	logic [num_lanes-1:0] decided;

	for (genvar j = 0; j < num_lanes; j++) begin : g_lane
		logic s_prev;
		logic s_next;
		logic signed [cp-1:0] c_n1;
		logic [ew-1:0] err_keep;
		logic [ew-1:0] err_flip;

		// neighbors cross the word boundary at the edge lanes.
		if (j == 0) begin : g_first
			assign s_prev = bits_prev_i[num_lanes-1];
		end else begin : g_inner_prev
			assign s_prev = bits_cur_i[j-1];
		end
		if (j == num_lanes - 1) begin : g_last
			assign s_next = bits_next_i[0];
			assign c_n1 = $signed(codes_next_i[0]);
		end else begin : g_inner_next
			assign s_next = bits_cur_i[j+1];
			assign c_n1 = $signed(codes_cur_i[j+1]);
		end

		assign err_keep = sat_err(hyp_err($signed(codes_cur_i[j]), c_n1, chan_est_i[j][0],
			chan_est_i[j][1], s_prev, bits_cur_i[j], s_next) >> shift_i[j]);
		assign err_flip = sat_err(hyp_err($signed(codes_cur_i[j]), c_n1, chan_est_i[j][0],
			chan_est_i[j][1], s_prev, ~bits_cur_i[j], s_next) >> shift_i[j]);

		assign decided[j] = (err_keep <= err_flip) ? bits_cur_i[j] : ~bits_cur_i[j]; // ties keep.
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			checked_o <= '0;
		end else begin
			checked_o <= decided;
		end
	end

endmodule : mlsd_checker

//--- hdl/sample_delay_line.sv
module sample_delay_line #(
	parameter type payload_t = logic,
	parameter int depth = 2
) (
	input logic clk,
	input logic rstb,

	input payload_t in_i,
	output payload_t line_o [depth-1:0]
);

	// stage 0 is the newest word.
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int i = 0; i < depth; i++) begin
				line_o[i] <= '0;
			end
		end else begin
			line_o[0] <= in_i;
			for (int i = 1; i < depth; i++) begin
				line_o[i] <= line_o[i-1];
			end
		end
	end

endmodule : sample_delay_line

//--- hdl/slicer.sv
module slicer #(
	parameter int num_lanes = dsp_backend_pkg::channel_width
) (
	input logic clk,
	input logic rstb,

	input logic signed [dsp_backend_pkg::output_precision-1:0] est_i [num_lanes-1:0],
	input logic signed [dsp_backend_pkg::thresh_precision-1:0] thresh_i [num_lanes-1:0],

	output logic [num_lanes-1:0] bit_o
);

	logic [num_lanes-1:0] above;

	// strictly greater, signed on both sides.
	always_comb begin
		for (int j = 0; j < num_lanes; j++) begin
			above[j] = est_i[j] > thresh_i[j];
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			bit_o <= '0;
		end else begin
			bit_o <= above;
		end
	end

endmodule : slicer

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f files.f --top-module tb_dsp_backend -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed"
	exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed"
	exit $status
fi

echo "simulation passed"
exit 0

//--- verification/tb_dsp_backend.sv
module tb_dsp_backend;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int lanes = dsp_backend_pkg::channel_width;
	localparam int taps = dsp_backend_pkg::ffe_length;
	localparam int cp = dsp_backend_pkg::code_precision;
	localparam int op = dsp_backend_pkg::output_precision;
	localparam int ep = dsp_backend_pkg::err_precision;
	localparam int caw = dsp_backend_pkg::cfg_addr_width;
	localparam int cdw = dsp_backend_pkg::cfg_data_width;
	localparam int wb = dsp_backend_pkg::cfg_weight_base;
	localparam int thb = dsp_backend_pkg::cfg_thresh_base;
	localparam int fsb = dsp_backend_pkg::cfg_ffe_shift_base;
	localparam int msb = dsp_backend_pkg::cfg_mlsd_shift_base;
	localparam int hb = dsp_backend_pkg::cfg_chan_est_base;

	logic clk;
	logic rstb;
	logic signed [cp-1:0] codes [lanes-1:0];
	logic cfg_wr;
	logic [caw-1:0] cfg_addr;
	logic [cdw-1:0] cfg_data;
	logic signed [op-1:0] estimated_bits [lanes-1:0];
	logic [lanes-1:0] checked_bits;

	// model copy of the configuration.
	int m_weight [taps][lanes];
	int m_thresh [lanes];
	int m_ffe_shift [lanes];
	int m_mlsd_shift [lanes];
	int m_h [lanes][2];

	// history, indexed by cycle mod 8.
	int code_buf [8][lanes];
	int est_buf [8][lanes];
	int bit_buf [8][lanes];
	int exp_chk [8][lanes];

	int word_in [lanes];
	int cyc = 8; // keeps t-4 non negative.
	int flips = 0;
	int prev_sym = -1;

	dsp_backend #(.channel_width(lanes), .ffe_length(taps)) DUT (
		.codes_i(codes),
		.clk(clk),
		.rstb(rstb),
		.cfg_wr_i(cfg_wr),
		.cfg_addr_i(cfg_addr),
		.cfg_data_i(cfg_data),
		.estimated_bits_o(estimated_bits),
		.checked_bits_o(checked_bits)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("FAIL time=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "output mismatch");
		end
	endtask

	function automatic int sext(input int v, input int w);
		int m;
		m = v & ((1 << w) - 1);
		if (m >= (1 << (w - 1)))
			m = m - (1 << w);
		return m;
	endfunction

	function automatic int abs_val(input int v);
		return (v < 0) ? -v : v;
	endfunction

	// symbols are +1 or -1.
	function automatic int mlsd_err(input int c0, input int c1, input int h0, input int h1,
			input int s_prev, input int s_cur, input int s_next, input int sh);
		int e;
		e = abs_val(c0 - (h0 * s_cur + h1 * s_prev)) + abs_val(c1 - (h0 * s_next + h1 * s_cur));
		e = e >> sh;
		if (e > (1 << ep) - 1)
			e = (1 << ep) - 1;
		return e;
	endfunction

	task automatic apply_cfg(input int addr, input int data);
		int a;
		int d;
		a = addr & ((1 << caw) - 1);
		d = data & ((1 << cdw) - 1);
		if (a >= wb && a < wb + taps * lanes)
			m_weight[(a - wb) / lanes][(a - wb) % lanes] = sext(d, dsp_backend_pkg::weight_precision);
		else if (a >= thb && a < thb + lanes)
			m_thresh[a - thb] = sext(d, dsp_backend_pkg::thresh_precision);
		else if (a >= fsb && a < fsb + lanes)
			m_ffe_shift[a - fsb] = d & ((1 << dsp_backend_pkg::shift_precision) - 1);
		else if (a >= msb && a < msb + lanes)
			m_mlsd_shift[a - msb] = d & ((1 << dsp_backend_pkg::shift_precision) - 1);
		else if (a >= hb && a < hb + 2 * lanes)
			m_h[(a - hb) / 2][(a - hb) % 2] = sext(d, dsp_backend_pkg::est_precision);
	endtask

	// estimate of word t, bits of word t-1, checked bits of word t-3.
	task automatic model_step(input int t);
		int acc;
		int c;
		int c1;
		int u;
		int b;
		int sp;
		int sx;
		int ek;
		int ef;
		for (int j = 0; j < lanes; j++) begin
			code_buf[t & 7][j] = sext(word_in[j], cp);
		end
		for (int j = 0; j < lanes; j++) begin
			acc = 0;
			for (int k = 0; k < taps; k++) begin
				if (j - k >= 0)
					c = code_buf[t & 7][j - k];
				else
					c = code_buf[(t - 1) & 7][lanes + j - k];
				acc = acc + m_weight[k][j] * c;
			end
			acc = acc >>> m_ffe_shift[j];
			if (acc > (1 << (op - 1)) - 1)
				acc = (1 << (op - 1)) - 1;
			else if (acc < -(1 << (op - 1)))
				acc = -(1 << (op - 1));
			est_buf[t & 7][j] = acc;
		end
		for (int j = 0; j < lanes; j++) begin
			bit_buf[(t - 1) & 7][j] = (est_buf[(t - 1) & 7][j] > m_thresh[j]) ? 1 : 0;
		end
		u = t - 3;
		for (int j = 0; j < lanes; j++) begin
			b = bit_buf[u & 7][j];
			sp = (j == 0) ? bit_buf[(u - 1) & 7][lanes - 1] : bit_buf[u & 7][j - 1];
			sx = (j == lanes - 1) ? bit_buf[(u + 1) & 7][0] : bit_buf[u & 7][j + 1];
			c1 = (j == lanes - 1) ? code_buf[(u + 1) & 7][0] : code_buf[u & 7][j + 1];
			ek = mlsd_err(code_buf[u & 7][j], c1, m_h[j][0], m_h[j][1],
				2 * sp - 1, 2 * b - 1, 2 * sx - 1, m_mlsd_shift[j]);
			ef = mlsd_err(code_buf[u & 7][j], c1, m_h[j][0], m_h[j][1],
				2 * sp - 1, 1 - 2 * b, 2 * sx - 1, m_mlsd_shift[j]);
			if (ek <= ef) begin
				exp_chk[t & 7][j] = b;
			end else begin
				exp_chk[t & 7][j] = 1 - b;
				flips++;
			end
		end
	endtask

	// drive one word, then compare what the DUT shows two edges later.
	task automatic cycle(input bit wr, input int addr, input int data);
		int t;
		@(posedge clk);
		for (int j = 0; j < lanes; j++) begin
			codes[j] <= cp'(word_in[j]);
		end
		cfg_wr <= wr;
		cfg_addr <= caw'(addr);
		cfg_data <= cdw'(data);
		cyc++;
		t = cyc;
		if (wr)
			apply_cfg(addr, data);
		model_step(t);
		@(negedge clk);
		for (int j = 0; j < lanes; j++) begin
			check_value($sformatf("estimated_bits_o[%0d]", j), est_buf[(t - 2) & 7][j],
				int'(estimated_bits[j]));
			check_value($sformatf("checked_bits_o[%0d]", j), exp_chk[(t - 2) & 7][j],
				int'(checked_bits[j]));
		end
	endtask

	task automatic random_word();
		for (int j = 0; j < lanes; j++) begin
			word_in[j] = sext($urandom_range((1 << cp) - 1, 0), cp);
		end
	endtask

	// noisy h0*s + h1*s_prev per sample.
	task automatic channel_word();
		int s;
		int c;
		for (int j = 0; j < lanes; j++) begin
			s = ($urandom_range(1, 0) == 1) ? 1 : -1;
			c = m_h[j][0] * s + m_h[j][1] * prev_sym + int'($urandom_range(40, 0)) - 20;
			if (c > (1 << (cp - 1)) - 1)
				c = (1 << (cp - 1)) - 1;
			else if (c < -(1 << (cp - 1)))
				c = -(1 << (cp - 1));
			word_in[j] = c;
			prev_sym = s;
		end
	endtask

	task automatic write_cfg(input int addr, input int data);
		random_word();
		cycle(1'b1, addr, data);
	endtask

	task automatic expect_zero();
		for (int j = 0; j < lanes; j++) begin
			check_value($sformatf("estimated_bits_o[%0d]", j), 0, int'(estimated_bits[j]));
			check_value($sformatf("checked_bits_o[%0d]", j), 0, int'(checked_bits[j]));
		end
	endtask

	task automatic stream_until_flip(input int min_words, input int limit);
		int n;
		n = 0;
		while (n < limit && (n < min_words || flips == 0)) begin
			channel_word();
			cycle(1'b0, 0, 0);
			n++;
		end
		if (flips == 0) begin
			$display("timeout: no MLSD flip seen in %0d words", n);
			$display("ERRORS FOUND");
			$fatal(1, "flip path never exercised");
		end
	endtask

	initial begin
		rstb = 1'b0;
		cfg_wr = 1'b0;
		cfg_addr = '0;
		cfg_data = '0;
		for (int j = 0; j < lanes; j++) begin
			codes[j] = '0;
		end
		void'($urandom(32'hd9d22f68));
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			expect_zero();
		end
		@(posedge clk);
		rstb <= 1'b1;
		for (int i = 0; i < 8; i++) begin
			random_word();
			cycle(1'b0, 0, 0);
			expect_zero(); // zero config.
		end

		// a unit cursor makes the estimates follow the codes.
		for (int j = 0; j < lanes; j++) begin
			write_cfg(wb + j, 1);
		end
		for (int i = 0; i < 20; i++) begin
			random_word();
			cycle(1'b0, 0, 0);
			for (int j = 0; j < lanes; j++) begin
				if (i >= 2)
					check_value($sformatf("estimated_bits_o[%0d]", j),
						code_buf[(cyc - 2) & 7][j], int'(estimated_bits[j]));
			end
		end

		// small shifts so that many lanes saturate.
		for (int k = 0; k < taps; k++) begin
			for (int j = 0; j < lanes; j++) begin
				write_cfg(wb + k * lanes + j, $urandom_range((1 << cdw) - 1, 0));
			end
		end
		for (int j = 0; j < lanes; j++) begin
			write_cfg(fsb + j, ($urandom_range(63, 0) << 4) | $urandom_range(5, 0));
		end
		for (int i = 0; i < 500; i++) begin
			random_word();
			cycle(1'b0, 0, 0);
		end

		for (int j = 0; j < lanes; j++) begin
			write_cfg(thb + j, $urandom_range((1 << cdw) - 1, 0));
		end
		for (int i = 0; i < 200; i++) begin
			random_word();
			cycle(1'b0, 0, 0);
		end

		// plain slicer on the raw code, then a real channel estimate.
		for (int k = 0; k < taps; k++) begin
			for (int j = 0; j < lanes; j++) begin
				write_cfg(wb + k * lanes + j, (k == 0) ? 1 : 0);
			end
		end
		for (int j = 0; j < lanes; j++) begin
			write_cfg(thb + j, 0);
			write_cfg(fsb + j, 0);
			write_cfg(hb + 2 * j, $urandom_range(60, 30));
			write_cfg(hb + 2 * j + 1, int'($urandom_range(50, 0)) - 25);
			write_cfg(msb + j, $urandom_range(2, 0));
		end
		flips = 0;
		stream_until_flip(300, 3000);

		write_cfg(40, (1 << cdw) - 1);
		write_cfg((1 << caw) - 1, 7);
		for (int i = 0; i < 300; i++) begin
			random_word();
			if ($urandom_range(3, 0) == 0)
				cycle(1'b1, $urandom_range((1 << caw) - 1, 0), $urandom_range((1 << cdw) - 1, 0));
			else
				cycle(1'b0, 0, 0);
		end
		for (int i = 0; i < 6; i++) begin
			random_word();
			cycle(1'b0, 0, 0);
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule : tb_dsp_backend
